// File: common/periph_pkg.sv
/* Bus widths, AXI response codes and the default address map of the peripheral subsystem.
   Imported by the RTL blocks and by the testbench to build addresses. */

`default_nettype none

package periph_pkg;

   // ----------------------------------------------------------
   // Bus types
   // ----------------------------------------------------------
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [3:0]  strb_t;
   typedef logic [1:0]  resp_t;

   // Timer and compare values
   typedef logic [63:0] mtime_t;

   // AXI response codes
   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;
   localparam resp_t RESP_DECERR = 2'b11;

   // ----------------------------------------------------------
   // Default address map
   // ----------------------------------------------------------
   localparam addr_t CLINT_BASE_DEF   = 32'h0200_0000;
   localparam addr_t CLINT_LENGTH_DEF = 32'h000C_0000;
   localparam addr_t APB_BASE_DEF     = 32'h6000_0000;
   localparam addr_t APB_LENGTH_DEF   = 32'h1000_0000;

   // CLINT register offsets, high words at offset plus 4
   localparam logic [15:0] CLINT_MSIP_OFS     = 16'h0000;
   localparam logic [15:0] CLINT_MTIMECMP_OFS = 16'h4000;
   localparam logic [15:0] CLINT_MTIME_OFS    = 16'hBFF8;

endpackage

`default_nettype wire

// File: rtl/axil_slave_fsm.sv
/* AXI4-Lite slave handling one transaction at a time, decoded by address
   to the CLINT, the APB port or a DECERR response. */

`default_nettype none

module axil_slave_fsm #(
   parameter periph_pkg::addr_t CLINT_BASE   = periph_pkg::CLINT_BASE_DEF,
   parameter periph_pkg::addr_t CLINT_LENGTH = periph_pkg::CLINT_LENGTH_DEF,
   parameter periph_pkg::addr_t APB_BASE     = periph_pkg::APB_BASE_DEF,
   parameter periph_pkg::addr_t APB_LENGTH   = periph_pkg::APB_LENGTH_DEF
) (
   input  logic              clk,
   input  logic              rstn,
   input  periph_pkg::addr_t s_awaddr_i,
   input  logic              s_awvalid_i,
   output logic              s_awready_o,
   input  periph_pkg::data_t s_wdata_i,
   input  periph_pkg::strb_t s_wstrb_i,
   input  logic              s_wvalid_i,
   output logic              s_wready_o,
   output periph_pkg::resp_t s_bresp_o,
   output logic              s_bvalid_o,
   input  logic              s_bready_i,
   input  periph_pkg::addr_t s_araddr_i,
   input  logic              s_arvalid_i,
   output logic              s_arready_o,
   output periph_pkg::data_t s_rdata_o,
   output periph_pkg::resp_t s_rresp_o,
   output logic              s_rvalid_o,
   input  logic              s_rready_i,
   // CLINT access, answered in the same cycle
   output logic              clint_req_o,
   output logic              clint_we_o,
   output periph_pkg::addr_t clint_addr_o,
   output periph_pkg::data_t clint_wdata_o,
   output periph_pkg::strb_t clint_wstrb_o,
   input  periph_pkg::data_t clint_rdata_i,
   input  logic              clint_err_i,
   // APB request, finished by done
   output logic              apb_req_o,
   output logic              apb_we_o,
   output periph_pkg::addr_t apb_addr_o,
   output periph_pkg::data_t apb_wdata_o,
   input  periph_pkg::data_t apb_rdata_i,
   input  logic              apb_err_i,
   input  logic              apb_done_i
);
   import periph_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DECODE,
      ST_APB_WAIT,
      ST_RESP
   } state_e;

   state_e state_q, state_d;
   logic   we_q;
   addr_t  addr_q;
   data_t  wdata_q, rdata_q;
   strb_t  wstrb_q;
   resp_t  resp_q;
   logic   wr_accept, rd_accept, resp_taken;
   logic   clint_hit, apb_hit;

   // Writes win over reads when both are pending
   assign wr_accept = (state_q == ST_IDLE) && s_awvalid_i && s_wvalid_i;
   assign rd_accept = (state_q == ST_IDLE) && !wr_accept && s_arvalid_i;

   assign s_awready_o = wr_accept;
   assign s_wready_o  = wr_accept;
   assign s_arready_o = rd_accept;

   // Offset compare wraps below base, so one test covers both bounds
   assign clint_hit = (addr_q - CLINT_BASE) < CLINT_LENGTH;
   assign apb_hit   = !clint_hit && ((addr_q - APB_BASE) < APB_LENGTH);

   // ----------------------------------------------------------
   // Target requests
   // ----------------------------------------------------------
   assign clint_req_o   = (state_q == ST_DECODE) && clint_hit;
   assign clint_we_o    = we_q;
   assign clint_addr_o  = addr_q;
   assign clint_wdata_o = wdata_q;
   assign clint_wstrb_o = wstrb_q;

   assign apb_req_o   = (state_q == ST_DECODE) && apb_hit;
   assign apb_we_o    = we_q;
   assign apb_addr_o  = addr_q;
   assign apb_wdata_o = wdata_q;

   // ----------------------------------------------------------
   // Response channels
   // ----------------------------------------------------------
   assign s_bvalid_o = (state_q == ST_RESP) && we_q;
   assign s_rvalid_o = (state_q == ST_RESP) && !we_q;
   assign s_bresp_o  = resp_q;
   assign s_rresp_o  = resp_q;
   assign s_rdata_o  = rdata_q;

   assign resp_taken = we_q ? s_bready_i : s_rready_i;

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         ST_IDLE: begin
            if (wr_accept || rd_accept) begin
               state_d = ST_DECODE;
            end
         end
         ST_DECODE: begin
            state_d = apb_hit ? ST_APB_WAIT : ST_RESP;
         end
         ST_APB_WAIT: begin
            if (apb_done_i) begin
               state_d = ST_RESP;
            end
         end
         ST_RESP: begin
            if (resp_taken) begin
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state_q <= ST_IDLE;
         we_q    <= 1'b0;
      end else begin
         state_q <= state_d;
         if (wr_accept) begin
            we_q <= 1'b1;
         end else if (rd_accept) begin
            we_q <= 1'b0;
         end
      end
   end

   // Request payload and response data
   always_ff @(posedge clk) begin
      if (wr_accept) begin
         addr_q  <= s_awaddr_i;
         wdata_q <= s_wdata_i;
         wstrb_q <= s_wstrb_i;
      end else if (rd_accept) begin
         addr_q <= s_araddr_i;
      end
      if (state_q == ST_DECODE && !apb_hit) begin
         if (clint_hit) begin
            rdata_q <= clint_rdata_i;
            resp_q  <= clint_err_i ? RESP_SLVERR : RESP_OKAY;
         end else begin
            rdata_q <= '0;
            resp_q  <= RESP_DECERR;
         end
      end
      if (state_q == ST_APB_WAIT && apb_done_i) begin
         rdata_q <= apb_rdata_i;
         resp_q  <= apb_err_i ? RESP_SLVERR : RESP_OKAY;
      end
   end

endmodule

`default_nettype wire

// File: clint/clint_timer.sv
/* Core-local timer with mtime, mtimecmp and msip registers behind a one-cycle
   register port, driving the timer and software interrupts. */

`default_nettype none

module clint_timer (
   input  logic              clk,
   input  logic              rstn,
   input  logic              clint_req_i,
   input  logic              clint_we_i,
   input  periph_pkg::addr_t clint_addr_i,
   input  periph_pkg::data_t clint_wdata_i,
   input  periph_pkg::strb_t clint_wstrb_i,
   output periph_pkg::data_t clint_rdata_o,
   output logic              clint_err_o,
   output logic              timer_irq_o,
   output logic              ipi_o
);
   import periph_pkg::*;

   logic        tick_q;
   mtime_t      mtime_q, mtime_d;
   mtime_t      mtimecmp_q, mtimecmp_d;
   logic        msip_q, msip_d;
   logic [15:0] ofs;
   logic        wr;
   logic        sel_msip, sel_cmp_lo, sel_cmp_hi, sel_time_lo, sel_time_hi;

   // Byte lanes with a set strobe take the new value
   function automatic data_t merge_strb(data_t old_v, data_t new_v, strb_t strb);
      data_t res;
      for (int i = 0; i < $bits(strb_t); i++) begin
         res[8*i +: 8] = strb[i] ? new_v[8*i +: 8] : old_v[8*i +: 8];
      end
      return res;
   endfunction

   // ----------------------------------------------------------
   // Register decode
   // ----------------------------------------------------------
   assign ofs = clint_addr_i[15:0];
   assign wr  = clint_req_i && clint_we_i;

   assign sel_msip    = (ofs == CLINT_MSIP_OFS);
   assign sel_cmp_lo  = (ofs == CLINT_MTIMECMP_OFS);
   assign sel_cmp_hi  = (ofs == CLINT_MTIMECMP_OFS + 16'd4);
   assign sel_time_lo = (ofs == CLINT_MTIME_OFS);
   assign sel_time_hi = (ofs == CLINT_MTIME_OFS + 16'd4);

   assign clint_err_o = clint_req_i &&
                        !(sel_msip || sel_cmp_lo || sel_cmp_hi || sel_time_lo || sel_time_hi);

   always_comb begin
      clint_rdata_o = '0;
      if (sel_msip) begin
         clint_rdata_o = {31'b0, msip_q};
      end else if (sel_cmp_lo) begin
         clint_rdata_o = mtimecmp_q[31:0];
      end else if (sel_cmp_hi) begin
         clint_rdata_o = mtimecmp_q[63:32];
      end else if (sel_time_lo) begin
         clint_rdata_o = mtime_q[31:0];
      end else if (sel_time_hi) begin
         clint_rdata_o = mtime_q[63:32];
      end
   end

   // ----------------------------------------------------------
   // Next register values
   // ----------------------------------------------------------
   always_comb begin
      // Counts on every other clk, a software write takes precedence
      mtime_d = tick_q ? mtime_q + 64'd1 : mtime_q;
      if (wr && sel_time_lo) begin
         mtime_d = {mtime_q[63:32], merge_strb(mtime_q[31:0], clint_wdata_i, clint_wstrb_i)};
      end else if (wr && sel_time_hi) begin
         mtime_d = {merge_strb(mtime_q[63:32], clint_wdata_i, clint_wstrb_i), mtime_q[31:0]};
      end

      mtimecmp_d = mtimecmp_q;
      if (wr && sel_cmp_lo) begin
         mtimecmp_d[31:0] = merge_strb(mtimecmp_q[31:0], clint_wdata_i, clint_wstrb_i);
      end else if (wr && sel_cmp_hi) begin
         mtimecmp_d[63:32] = merge_strb(mtimecmp_q[63:32], clint_wdata_i, clint_wstrb_i);
      end

      msip_d = msip_q;
      if (wr && sel_msip && clint_wstrb_i[0]) begin
         msip_d = clint_wdata_i[0];
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         tick_q      <= 1'b0;
         mtime_q     <= '0;
         mtimecmp_q  <= '1;
         msip_q      <= 1'b0;
         timer_irq_o <= 1'b0;
         ipi_o       <= 1'b0;
      end else begin
         tick_q      <= ~tick_q;
         mtime_q     <= mtime_d;
         mtimecmp_q  <= mtimecmp_d;
         msip_q      <= msip_d;
         // Interrupts track the registers one cycle later
         timer_irq_o <= (mtime_q >= mtimecmp_q);
         ipi_o       <= msip_q;
      end
   end

endmodule

`default_nettype wire

// File: apb/apb_master_port.sv
/* APB3 master sequencing one request at a time through setup and access,
   returning read data and error with a one-cycle done pulse. */

`default_nettype none

module apb_master_port (
   input  logic              clk,
   input  logic              rstn,
   input  logic              apb_req_i,
   input  logic              apb_we_i,
   input  periph_pkg::addr_t apb_addr_i,
   input  periph_pkg::data_t apb_wdata_i,
   output periph_pkg::data_t apb_rdata_o,
   output logic              apb_err_o,
   output logic              apb_done_o,
   // APB3 bus
   output logic              psel_o,
   output logic              penable_o,
   output logic              pwrite_o,
   output periph_pkg::addr_t paddr_o,
   output periph_pkg::data_t pwdata_o,
   input  periph_pkg::data_t prdata_i,
   input  logic              pready_i,
   input  logic              pslverr_i
);
   import periph_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SETUP,
      ST_ACCESS
   } state_e;

   state_e state_q;
   logic   we_q;
   addr_t  addr_q;
   data_t  wdata_q;
   logic   xfer_end;

   assign xfer_end = (state_q == ST_ACCESS) && pready_i;

   assign psel_o    = (state_q != ST_IDLE);
   assign penable_o = (state_q == ST_ACCESS);
   assign pwrite_o  = we_q;
   assign paddr_o   = addr_q;
   assign pwdata_o  = wdata_q;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state_q    <= ST_IDLE;
         we_q       <= 1'b0;
         apb_done_o <= 1'b0;
      end else begin
         apb_done_o <= xfer_end;
         unique case (state_q)
            ST_IDLE: begin
               if (apb_req_i) begin
                  state_q <= ST_SETUP;
                  we_q    <= apb_we_i;
               end
            end
            ST_SETUP: state_q <= ST_ACCESS;
            ST_ACCESS: begin
               // Access holds until the slave is ready
               if (pready_i) begin
                  state_q <= ST_IDLE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Request payload and captured completion
   always_ff @(posedge clk) begin
      if (state_q == ST_IDLE && apb_req_i) begin
         addr_q  <= apb_addr_i;
         wdata_q <= apb_wdata_i;
      end
      if (xfer_end) begin
         apb_rdata_o <= prdata_i;
         apb_err_o   <= pslverr_i;
      end
   end

endmodule

`default_nettype wire

// File: rtl/periph_subsys.sv
/* Peripheral subsystem top: one AXI4-Lite slave port decoded onto the CLINT timer
   and an external APB3 master port. */

`default_nettype none

module periph_subsys #(
   parameter periph_pkg::addr_t CLINT_BASE   = periph_pkg::CLINT_BASE_DEF,
   parameter periph_pkg::addr_t CLINT_LENGTH = periph_pkg::CLINT_LENGTH_DEF,
   parameter periph_pkg::addr_t APB_BASE     = periph_pkg::APB_BASE_DEF,
   parameter periph_pkg::addr_t APB_LENGTH   = periph_pkg::APB_LENGTH_DEF
) (
   input  logic              clk,
   input  logic              rstn,
   // AXI4-Lite slave
   input  periph_pkg::addr_t s_awaddr_i,
   input  logic              s_awvalid_i,
   output logic              s_awready_o,
   input  periph_pkg::data_t s_wdata_i,
   input  periph_pkg::strb_t s_wstrb_i,
   input  logic              s_wvalid_i,
   output logic              s_wready_o,
   output periph_pkg::resp_t s_bresp_o,
   output logic              s_bvalid_o,
   input  logic              s_bready_i,
   input  periph_pkg::addr_t s_araddr_i,
   input  logic              s_arvalid_i,
   output logic              s_arready_o,
   output periph_pkg::data_t s_rdata_o,
   output periph_pkg::resp_t s_rresp_o,
   output logic              s_rvalid_o,
   input  logic              s_rready_i,
   // APB3 master
   output logic              psel_o,
   output logic              penable_o,
   output logic              pwrite_o,
   output periph_pkg::addr_t paddr_o,
   output periph_pkg::data_t pwdata_o,
   input  periph_pkg::data_t prdata_i,
   input  logic              pready_i,
   input  logic              pslverr_i,
   // Interrupts
   output logic              timer_irq_o,
   output logic              ipi_o
);
   import periph_pkg::*;

   logic  clint_req, clint_we, clint_err;
   addr_t clint_addr;
   data_t clint_wdata, clint_rdata;
   strb_t clint_wstrb;

   logic  apb_req, apb_we, apb_err, apb_done;
   addr_t apb_addr;
   data_t apb_wdata, apb_rdata;

   axil_slave_fsm #(
      .CLINT_BASE   (CLINT_BASE),
      .CLINT_LENGTH (CLINT_LENGTH),
      .APB_BASE     (APB_BASE),
      .APB_LENGTH   (APB_LENGTH)
   ) i_axil_slave_fsm (
      .clk           (clk),
      .rstn          (rstn),
      .s_awaddr_i    (s_awaddr_i),
      .s_awvalid_i   (s_awvalid_i),
      .s_awready_o   (s_awready_o),
      .s_wdata_i     (s_wdata_i),
      .s_wstrb_i     (s_wstrb_i),
      .s_wvalid_i    (s_wvalid_i),
      .s_wready_o    (s_wready_o),
      .s_bresp_o     (s_bresp_o),
      .s_bvalid_o    (s_bvalid_o),
      .s_bready_i    (s_bready_i),
      .s_araddr_i    (s_araddr_i),
      .s_arvalid_i   (s_arvalid_i),
      .s_arready_o   (s_arready_o),
      .s_rdata_o     (s_rdata_o),
      .s_rresp_o     (s_rresp_o),
      .s_rvalid_o    (s_rvalid_o),
      .s_rready_i    (s_rready_i),
      .clint_req_o   (clint_req),
      .clint_we_o    (clint_we),
      .clint_addr_o  (clint_addr),
      .clint_wdata_o (clint_wdata),
      .clint_wstrb_o (clint_wstrb),
      .clint_rdata_i (clint_rdata),
      .clint_err_i   (clint_err),
      .apb_req_o     (apb_req),
      .apb_we_o      (apb_we),
      .apb_addr_o    (apb_addr),
      .apb_wdata_o   (apb_wdata),
      .apb_rdata_i   (apb_rdata),
      .apb_err_i     (apb_err),
      .apb_done_i    (apb_done)
   );

   clint_timer i_clint_timer (
      .clk           (clk),
      .rstn          (rstn),
      .clint_req_i   (clint_req),
      .clint_we_i    (clint_we),
      .clint_addr_i  (clint_addr),
      .clint_wdata_i (clint_wdata),
      .clint_wstrb_i (clint_wstrb),
      .clint_rdata_o (clint_rdata),
      .clint_err_o   (clint_err),
      .timer_irq_o   (timer_irq_o),
      .ipi_o         (ipi_o)
   );

   apb_master_port i_apb_master_port (
      .clk         (clk),
      .rstn        (rstn),
      .apb_req_i   (apb_req),
      .apb_we_i    (apb_we),
      .apb_addr_i  (apb_addr),
      .apb_wdata_i (apb_wdata),
      .apb_rdata_o (apb_rdata),
      .apb_err_o   (apb_err),
      .apb_done_o  (apb_done),
      .psel_o      (psel_o),
      .penable_o   (penable_o),
      .pwrite_o    (pwrite_o),
      .paddr_o     (paddr_o),
      .pwdata_o    (pwdata_o),
      .prdata_i    (prdata_i),
      .pready_i    (pready_i),
      .pslverr_i   (pslverr_i)
   );

endmodule

`default_nettype wire

// File: test/apb_mem_model.sv
/* APB3 slave for the testbench: 16-word memory below offset 0x40, error above it,
   with the wait states of each transfer taken from wait_i at the setup phase. */

`default_nettype none

module apb_mem_model #(
   parameter periph_pkg::addr_t BASE = periph_pkg::APB_BASE_DEF
) (
   input  logic              clk,
   input  logic              rstn,
   input  logic              psel_i,
   input  logic              penable_i,
   input  logic              pwrite_i,
   input  periph_pkg::addr_t paddr_i,
   input  periph_pkg::data_t pwdata_i,
   input  logic [1:0]        wait_i,
   output periph_pkg::data_t prdata_o,
   output logic              pready_o,
   output logic              pslverr_o
);
   import periph_pkg::*;

   data_t      mem [16];
   logic [1:0] wait_q;
   addr_t      ofs;
   logic       err;
   logic       access;

   assign ofs    = paddr_i - BASE;
   assign err    = (ofs >= 32'h40);
   assign access = psel_i && penable_i;

   assign pready_o  = access && (wait_q == 2'd0);
   assign pslverr_o = pready_o && err;
   assign prdata_o  = (pready_o && !pwrite_i && !err) ? mem[ofs[5:2]] : '0;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         wait_q <= '0;
         // Fill pattern carries the word index
         for (int i = 0; i < 16; i++) begin
            mem[i] <= {16'h5A5A, 12'h000, 4'(i)};
         end
      end else begin
         if (psel_i && !penable_i) begin
            wait_q <= wait_i;
         end else if (access && wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
         end
         if (pready_o && pwrite_i && !err) begin
            mem[ofs[5:2]] <= pwdata_i;
         end
      end
   end

endmodule

`default_nettype wire

// File: test/tb_periph_subsys.sv
/* Testbench for the peripheral subsystem: table-driven AXI4-Lite accesses to the CLINT,
   the APB memory model and unmapped space, with response and interrupt checks. */

`default_nettype none

module tb_periph_subsys;
   import periph_pkg::*;

   localparam int    TIMEOUT     = 200;
   localparam addr_t CLINT       = CLINT_BASE_DEF;
   localparam addr_t APB         = APB_BASE_DEF;
   localparam data_t MTIME_START = 32'h0000_1000;

   logic  clk;
   logic  rstn;
   addr_t s_awaddr, s_araddr;
   data_t s_wdata, s_rdata;
   strb_t s_wstrb;
   resp_t s_bresp, s_rresp;
   logic  s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
   logic  s_arvalid, s_arready, s_rvalid, s_rready;
   logic  psel, penable, pwrite, pready, pslverr;
   addr_t paddr;
   data_t pwdata, prdata;
   logic  timer_irq, ipi;

   logic [31:0] lfsr_q;
   logic [1:0]  wait_states;
   logic        ready_rand;

   int   errors;
   int   tests_run;
   int   tests_failed;
   logic test_bad;
   logic aborted;

   // Stimulus table held as one queue per column
   string row_name  [$];
   logic  row_we    [$];
   addr_t row_addr  [$];
   data_t row_wdata [$];
   strb_t row_strb  [$];
   resp_t row_resp  [$];
   data_t row_rdata [$];
   logic  row_irq   [$];
   logic  row_ipi   [$];

   periph_subsys i_periph_subsys (
      .clk(clk), .rstn(rstn),
      .s_awaddr_i(s_awaddr), .s_awvalid_i(s_awvalid), .s_awready_o(s_awready),
      .s_wdata_i(s_wdata), .s_wstrb_i(s_wstrb), .s_wvalid_i(s_wvalid), .s_wready_o(s_wready),
      .s_bresp_o(s_bresp), .s_bvalid_o(s_bvalid), .s_bready_i(s_bready),
      .s_araddr_i(s_araddr), .s_arvalid_i(s_arvalid), .s_arready_o(s_arready),
      .s_rdata_o(s_rdata), .s_rresp_o(s_rresp), .s_rvalid_o(s_rvalid), .s_rready_i(s_rready),
      .psel_o(psel), .penable_o(penable), .pwrite_o(pwrite), .paddr_o(paddr),
      .pwdata_o(pwdata), .prdata_i(prdata), .pready_i(pready), .pslverr_i(pslverr),
      .timer_irq_o(timer_irq), .ipi_o(ipi)
   );

   apb_mem_model i_apb_mem_model (
      .clk(clk), .rstn(rstn),
      .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
      .pwdata_i(pwdata), .wait_i(wait_states),
      .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // Wait states and response readies take one LFSR step per bit
   always @(posedge clk) begin : rand_gen
      logic [31:0] s;
      logic [2:0]  bits;
      s = lfsr_q;
      for (int i = 0; i < 3; i++) begin
         bits[i] = s[0];
         s = lfsr_next(s);
      end
      lfsr_q      <= s;
      wait_states <= bits[1:0];
      ready_rand  <= bits[2];
   end

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         errors++;
         test_bad = 1'b1;
      end
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (test_bad) begin
         tests_failed++;
         $display("%s: failed", name);
      end else begin
         $display("%s: passed", name);
      end
   endtask

   task automatic add_row(input string name, input logic we, input addr_t addr,
                          input data_t wdata, input strb_t strb, input resp_t resp,
                          input data_t rdata, input logic irq, input logic ipi_lvl);
      row_name.push_back(name);
      row_we.push_back(we);
      row_addr.push_back(addr);
      row_wdata.push_back(wdata);
      row_strb.push_back(strb);
      row_resp.push_back(resp);
      row_rdata.push_back(rdata);
      row_irq.push_back(irq);
      row_ipi.push_back(ipi_lvl);
   endtask

   // ------------------------------------------------------------
   // Stimulus table
   // ------------------------------------------------------------
   task automatic build_table();
      add_row("cmp_lo_reset", 0, CLINT + CLINT_MTIMECMP_OFS, 0, 0, RESP_OKAY, 32'hFFFF_FFFF, 0, 0);
      add_row("apb_write_w3", 1, APB + 32'h0C, 32'hCAFE_0003, 4'hF, RESP_OKAY, 0, 0, 0);
      add_row("apb_write_w5", 1, APB + 32'h14, 32'h1234_5678, 4'hF, RESP_OKAY, 0, 0, 0);
      add_row("apb_read_w3", 0, APB + 32'h0C, 0, 0, RESP_OKAY, 32'hCAFE_0003, 0, 0);
      add_row("apb_read_w5", 0, APB + 32'h14, 0, 0, RESP_OKAY, 32'h1234_5678, 0, 0);
      add_row("apb_write_err", 1, APB + 32'h40, 32'h0BAD_0040, 4'hF, RESP_SLVERR, 0, 0, 0);
      add_row("apb_read_err", 0, APB + 32'h80, 0, 0, RESP_SLVERR, 0, 0, 0);
      add_row("decerr_read", 0, 32'h1000_0000, 0, 0, RESP_DECERR, 0, 0, 0);
      add_row("decerr_write", 1, 32'h4000_0000, 32'h1111_2222, 4'hF, RESP_DECERR, 0, 0, 0);
      add_row("clint_bad_ofs", 0, CLINT + 32'h0100, 0, 0, RESP_SLVERR, 0, 0, 0);
      add_row("msip_set", 1, CLINT + CLINT_MSIP_OFS, 1, 4'hF, RESP_OKAY, 0, 0, 1);
      add_row("msip_read", 0, CLINT + CLINT_MSIP_OFS, 0, 0, RESP_OKAY, 1, 0, 1);
      add_row("msip_clear", 1, CLINT + CLINT_MSIP_OFS, 0, 4'hF, RESP_OKAY, 0, 0, 0);
      add_row("mtime_lo_write", 1, CLINT + CLINT_MTIME_OFS, 32'h100, 4'hF, RESP_OKAY, 0, 0, 0);
      add_row("mtime_hi_write", 1, CLINT + CLINT_MTIME_OFS + 4, 0, 4'hF, RESP_OKAY, 0, 0, 0);
      add_row("cmp_lo_write", 1, CLINT + CLINT_MTIMECMP_OFS, 32'h80, 4'hF, RESP_OKAY, 0, 0, 0);
      add_row("cmp_hi_zero", 1, CLINT + CLINT_MTIMECMP_OFS + 4, 0, 4'hF, RESP_OKAY, 0, 1, 0);
      add_row("cmp_hi_ones", 1, CLINT + CLINT_MTIMECMP_OFS + 4, '1, 4'hF, RESP_OKAY, 0, 0, 0);
      // Upper bytes set so that the byte-0 write shows they are kept
      add_row("cmp_lo_full", 1, CLINT + CLINT_MTIMECMP_OFS, 32'hA5A5_A580, 4'hF, RESP_OKAY,
              0, 0, 0);
      add_row("cmp_lo_byte0", 1, CLINT + CLINT_MTIMECMP_OFS, 32'hDEAD_BE11, 4'h1, RESP_OKAY,
              0, 0, 0);
      add_row("cmp_lo_read", 0, CLINT + CLINT_MTIMECMP_OFS, 0, 0, RESP_OKAY, 32'hA5A5_A511,
              0, 0);
   endtask

   // One AXI4-Lite transaction from request to response handshake
   task automatic axi_access(input logic we, input addr_t addr, input data_t wdata,
                             input strb_t strb, output resp_t resp, output data_t rdata);
      int   cnt;
      logic done;
      resp  = '0;
      rdata = '0;
      if (!aborted) begin
         if (we) begin
            s_awaddr  <= addr;
            s_wdata   <= wdata;
            s_wstrb   <= strb;
            s_awvalid <= 1'b1;
            s_wvalid  <= 1'b1;
         end else begin
            s_araddr  <= addr;
            s_arvalid <= 1'b1;
         end
         cnt  = 0;
         done = 1'b0;
         while (!done && cnt < TIMEOUT) begin
            @(posedge clk);
            done = we ? (s_awready && s_wready) : s_arready;
            cnt++;
         end
         s_awvalid <= 1'b0;
         s_wvalid  <= 1'b0;
         s_arvalid <= 1'b0;
         if (!done) begin
            $display("Timeout: request to address %h was never accepted", addr);
            aborted = 1'b1;
         end
      end
      if (!aborted) begin
         cnt  = 0;
         done = 1'b0;
         while (!done && cnt < TIMEOUT) begin
            // Random back-pressure on the response channel
            if (we) begin
               s_bready <= ready_rand;
            end else begin
               s_rready <= ready_rand;
            end
            @(posedge clk);
            done = we ? (s_bvalid && s_bready) : (s_rvalid && s_rready);
            cnt++;
         end
         s_bready <= 1'b0;
         s_rready <= 1'b0;
         if (done) begin
            resp  = we ? s_bresp : s_rresp;
            rdata = we ? '0 : s_rdata;
         end else begin
            $display("Timeout: no response for address %h", addr);
            aborted = 1'b1;
         end
      end
   endtask

   initial begin : main
      resp_t resp;
      data_t rdata;
      data_t first;
      data_t second;
      clk          = 1'b0;
      rstn         = 1'b0;
      lfsr_q       = 32'h34e8_3265;
      wait_states  = '0;
      ready_rand   = 1'b0;
      s_awaddr     = '0;
      s_awvalid    = 1'b0;
      s_wdata      = '0;
      s_wstrb      = '0;
      s_wvalid     = 1'b0;
      s_bready     = 1'b0;
      s_araddr     = '0;
      s_arvalid    = 1'b0;
      s_rready     = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      aborted      = 1'b0;

      repeat (16) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);

      // ------------------------------------------------------------
      // Idle outputs after reset
      // ------------------------------------------------------------
      test_bad = 1'b0;
      check_value("reset_outputs timer_irq", 0, timer_irq);
      check_value("reset_outputs ipi", 0, ipi);
      check_value("reset_outputs psel", 0, psel);
      check_value("reset_outputs bvalid", 0, s_bvalid);
      check_value("reset_outputs rvalid", 0, s_rvalid);
      report_test("reset_outputs");

      build_table();
      for (int i = 0; i < row_name.size() && !aborted; i++) begin
         test_bad = 1'b0;
         axi_access(row_we[i], row_addr[i], row_wdata[i], row_strb[i], resp, rdata);
         if (!aborted) begin
            check_value({row_name[i], " resp"}, row_resp[i], resp);
            if (!row_we[i]) begin
               check_value({row_name[i], " rdata"}, row_rdata[i], rdata);
            end
            // Interrupt outputs lag the registers by one cycle
            repeat (2) @(posedge clk);
            check_value({row_name[i], " timer_irq"}, row_irq[i], timer_irq);
            check_value({row_name[i], " ipi"}, row_ipi[i], ipi);
            report_test(row_name[i]);
         end
      end

      // mtime keeps counting after a write
      if (!aborted) begin
         test_bad = 1'b0;
         axi_access(1'b1, CLINT + CLINT_MTIME_OFS, MTIME_START, 4'hF, resp, rdata);
         check_value("mtime_count write resp", RESP_OKAY, resp);
         axi_access(1'b0, CLINT + CLINT_MTIME_OFS, 0, 0, resp, first);
         axi_access(1'b0, CLINT + CLINT_MTIME_OFS, 0, 0, resp, second);
         if (!aborted) begin
            check_value("mtime_count first above start", 1, first > MTIME_START);
            check_value("mtime_count second not below first", 1, second >= first);
            report_test("mtime_count");
         end
      end

      $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (aborted || errors != 0) begin
         $display("RESULT: FAIL");
      end else begin
         $display("RESULT: PASS");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: periph_subsys.f
common/periph_pkg.sv
rtl/axil_slave_fsm.sv
clint/clint_timer.sv
apb/apb_master_port.sv
rtl/periph_subsys.sv
test/apb_mem_model.sv
test/tb_periph_subsys.sv

// File: Bender.yml
package:
  name: periph_subsys

sources:
  - common/periph_pkg.sv
  - rtl/axil_slave_fsm.sv
  - clint/clint_timer.sv
  - apb/apb_master_port.sv
  - rtl/periph_subsys.sv
  - target: test
    files:
      - test/apb_mem_model.sv
      - test/tb_periph_subsys.sv
